//--- flist.f
logic/depar_pkg.sv
logic/cfg_pkg.sv
logic/hdr_store_if.sv
logic/act_cfg.sv
logic/hdr_store.sv
logic/depar_fsm.sv
logic/depar_top.sv
testbench/tb_clk_gen.sv
testbench/depar_assert.sv
testbench/depar_tb.sv

//--- logic/act_cfg.sv
`timescale 1ns/1ns
`default_nettype none

module act_cfg import depar_pkg::*, cfg_pkg::*; #(
	parameter logic [MOD_ID_W-1:0] DEPARSER_MOD_ID = 3'd5
) (
	input  wire logic              clk,
	input  wire logic              aresetn,
	input  wire logic              ctrl_tvalid,
	input  wire logic [DATA_W-1:0] ctrl_tdata,
	input  wire logic              ctrl_tlast,
	input  wire logic [VLAN_W-1:0] phv_vlan_id,
	output act_entry_t             entry
);

	cfg_state_t        state;
	logic [TBL_AW-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;
	logic              wr_en;
	logic              id_match;

	act_entry_t tbl [TBL_DEPTH];

	assign id_match = ctrl_tdata[MOD_ID_LSB +: MOD_ID_W] == DEPARSER_MOD_ID;

	// entry bytes arrive reversed
	always_comb begin
		for (int i = 0; i < DATA_W / 8; i++) begin
			wr_data[8*i +: 8] = ctrl_tdata[8*(DATA_W/8-1-i) +: 8];
		end
	end

	// only a two-beat packet writes
	assign wr_en = (state == WAIT_ENTRY) && ctrl_tvalid && ctrl_tlast;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= WAIT_HDR;
		end else if (ctrl_tvalid) begin
			case (state)
				WAIT_HDR: begin
					if (!ctrl_tlast) begin
						state <= id_match ? WAIT_ENTRY : SKIP_REST;
					end
				end
				WAIT_ENTRY: begin
					state <= ctrl_tlast ? WAIT_HDR : SKIP_REST;
				end
				SKIP_REST: begin
					if (ctrl_tlast) begin
						state <= WAIT_HDR;
					end
				end
				default: state <= WAIT_HDR;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == WAIT_HDR && ctrl_tvalid) begin
			wr_addr <= ctrl_tdata[CTRL_ADDR_LSB +: TBL_AW];
		end
	end

	// all entries start invalid
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < TBL_DEPTH; i++) begin
				tbl[i] <= '0;
			end
		end else if (wr_en) begin
			tbl[wr_addr] <= wr_data;
		end
	end

	// synchronous lookup on vlan id bits 8..4
	always_ff @(posedge clk) begin
		entry <= tbl[phv_vlan_id[TBL_IDX_LSB +: TBL_AW]];
	end

endmodule

`default_nettype wire

//--- logic/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

	// action table
	localparam int NUM_ACT     = 4;
	localparam int TBL_DEPTH   = 32;
	localparam int TBL_AW      = $clog2(TBL_DEPTH);
	localparam int TBL_IDX_LSB = 4;

	typedef struct packed {
		logic       valid;
		logic [4:0] offset;
		logic [2:0] cont;
		logic [6:0] rsvd;
	} action_t;

	// action 0 in the top 16 bits
	typedef action_t [0:NUM_ACT-1] act_entry_t;

	// control beat 0 fields
	localparam int MOD_ID_LSB    = 0;
	localparam int MOD_ID_W      = 3;
	localparam int CTRL_ADDR_LSB = 8;

	typedef enum logic [1:0] {
		WAIT_HDR,
		WAIT_ENTRY,
		SKIP_REST
	} cfg_state_t;

endpackage

`default_nettype wire

//--- logic/depar_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module depar_fsm import depar_pkg::*; (
	input  wire logic              clk,
	input  wire logic              aresetn,
	input  wire logic [DATA_W-1:0] pkt_tdata,
	input  wire logic [KEEP_W-1:0] pkt_tkeep,
	input  wire logic              pkt_tlast,
	input  wire logic              pkt_empty,
	output logic                   pkt_rd_en,
	input  wire logic              phv_empty,
	input  wire logic              phv_discard,
	output logic                   phv_rd_en,
	output logic [DATA_W-1:0]      out_tdata,
	output logic [KEEP_W-1:0]      out_tkeep,
	output logic                   out_tlast,
	output logic                   out_tvalid,
	input  wire logic              out_tready,
	hdr_store_if.fsm               store
);

	depar_state_t         state, state_nxt;
	logic [HDR_IDX_W-1:0] cap_cnt, cap_cnt_nxt;
	logic [HDR_IDX_W-1:0] rd_idx, rd_idx_nxt;
	logic                 last_seen, last_seen_nxt;
	logic                 emit_store;
	logic                 emit_fifo;

	// capture straight from the fifo head
	assign store.cap_idx  = cap_cnt;
	assign store.cap_data = pkt_tdata;
	assign store.cap_keep = pkt_tkeep;
	assign store.cap_last = pkt_tlast;
	assign store.rd_idx   = rd_idx;

	always_comb begin
		state_nxt      = state;
		cap_cnt_nxt    = cap_cnt;
		rd_idx_nxt     = rd_idx;
		last_seen_nxt  = last_seen;
		pkt_rd_en      = 1'b0;
		phv_rd_en      = 1'b0;
		store.cap_en   = 1'b0;
		store.patch_en = 1'b0;
		emit_store     = 1'b0;
		emit_fifo      = 1'b0;

		case (state)
			IDLE, CAPTURE: begin
				if (!pkt_empty && (state == CAPTURE || !phv_empty)) begin
					pkt_rd_en     = 1'b1;
					store.cap_en  = 1'b1;
					last_seen_nxt = pkt_tlast;
					if (pkt_tlast || cap_cnt == HDR_IDX_W'(HDR_BEATS - 1)) begin
						cap_cnt_nxt = '0;
						state_nxt   = LOOKUP;
					end else begin
						cap_cnt_nxt = cap_cnt + 1'b1;
						state_nxt   = CAPTURE;
					end
				end
			end
			// table entry is valid here
			LOOKUP: begin
				if (phv_discard) begin
					phv_rd_en = 1'b1;
					state_nxt = DROP;
				end else begin
					state_nxt = PATCH;
				end
			end
			PATCH: begin
				store.patch_en = 1'b1;
				phv_rd_en      = 1'b1;
				state_nxt      = FLUSH;
			end
			FLUSH: begin
				if (out_tready) begin
					emit_store = 1'b1;
					rd_idx_nxt = rd_idx + 1'b1;
					if (store.rd_last) begin
						rd_idx_nxt = '0;
						state_nxt  = IDLE;
					end else if (rd_idx == HDR_IDX_W'(HDR_BEATS - 1)) begin
						state_nxt = PASS;
					end
				end
			end
			PASS: begin
				if (!pkt_empty && out_tready) begin
					pkt_rd_en = 1'b1;
					emit_fifo = 1'b1;
					if (pkt_tlast) begin
						state_nxt = IDLE;
					end
				end
			end
			DROP: begin
				if (last_seen) begin
					state_nxt = IDLE;
				end else if (!pkt_empty) begin
					pkt_rd_en = 1'b1;
					if (pkt_tlast) begin
						state_nxt = IDLE;
					end
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state      <= IDLE;
			cap_cnt    <= '0;
			rd_idx     <= '0;
			last_seen  <= 1'b0;
			out_tvalid <= 1'b0;
		end else begin
			state      <= state_nxt;
			cap_cnt    <= cap_cnt_nxt;
			rd_idx     <= rd_idx_nxt;
			last_seen  <= last_seen_nxt;
			out_tvalid <= emit_store || emit_fifo;
		end
	end

	// output beat from the store or the fifo head
	always_ff @(posedge clk) begin
		if (emit_store) begin
			out_tdata <= store.rd_data;
			out_tkeep <= store.rd_keep;
			out_tlast <= store.rd_last;
		end else if (emit_fifo) begin
			out_tdata <= pkt_tdata;
			out_tkeep <= pkt_tkeep;
			out_tlast <= pkt_tlast;
		end
	end

endmodule

`default_nettype wire

//--- logic/depar_pkg.sv
`default_nettype none

package depar_pkg;

	// beat format
	localparam int DATA_W    = 64;
	localparam int KEEP_W    = DATA_W / 8;

	// header buffer
	localparam int HDR_BEATS = 4;
	localparam int HDR_BYTES = HDR_BEATS * KEEP_W;
	localparam int HDR_IDX_W = $clog2(HDR_BEATS);

	// phv layout, container c at bit 32*c
	localparam int CONT_W      = 32;
	localparam int NUM_CONT    = 8;
	localparam int PHV_W       = 272;
	localparam int VLAN_W      = 12;
	localparam int VLAN_LSB    = NUM_CONT * CONT_W;
	localparam int DISCARD_BIT = VLAN_LSB + VLAN_W;

	typedef enum logic [2:0] {
		IDLE,
		CAPTURE,
		LOOKUP,
		PATCH,
		FLUSH,
		PASS,
		DROP
	} depar_state_t;

endpackage

`default_nettype wire

//--- logic/depar_top.sv
`timescale 1ns/1ns
`default_nettype none

module depar_top import depar_pkg::*, cfg_pkg::*; #(
	parameter logic [MOD_ID_W-1:0] DEPARSER_MOD_ID = 3'd5
) (
	input  wire logic              clk,
	input  wire logic              aresetn,

	input  wire logic [DATA_W-1:0] pkt_tdata,
	input  wire logic [KEEP_W-1:0] pkt_tkeep,
	input  wire logic              pkt_tlast,
	input  wire logic              pkt_empty,
	output logic                   pkt_rd_en,

	input  wire logic [PHV_W-1:0]  phv_data,
	input  wire logic              phv_empty,
	output logic                   phv_rd_en,

	output logic [DATA_W-1:0]      out_tdata,
	output logic [KEEP_W-1:0]      out_tkeep,
	output logic                   out_tlast,
	output logic                   out_tvalid,
	input  wire logic              out_tready,

	input  wire logic              ctrl_tvalid,
	input  wire logic [DATA_W-1:0] ctrl_tdata,
	input  wire logic              ctrl_tlast
);

	logic [NUM_CONT*CONT_W-1:0] phv_cont;
	logic [VLAN_W-1:0]          phv_vlan_id;
	logic                       phv_discard;
	act_entry_t                 entry;

	assign phv_cont    = phv_data[NUM_CONT*CONT_W-1:0];
	assign phv_vlan_id = phv_data[VLAN_LSB +: VLAN_W];
	assign phv_discard = phv_data[DISCARD_BIT];

	hdr_store_if u_hdr_if ();

	act_cfg #(
		.DEPARSER_MOD_ID (DEPARSER_MOD_ID)
	) u_act_cfg (
		.clk         (clk),
		.aresetn     (aresetn),
		.ctrl_tvalid (ctrl_tvalid),
		.ctrl_tdata  (ctrl_tdata),
		.ctrl_tlast  (ctrl_tlast),
		.phv_vlan_id (phv_vlan_id),
		.entry       (entry)
	);

	hdr_store u_hdr_store (
		.clk      (clk),
		.aresetn  (aresetn),
		.store    (u_hdr_if.store),
		.entry    (entry),
		.phv_cont (phv_cont)
	);

	depar_fsm u_depar_fsm (
		.clk         (clk),
		.aresetn     (aresetn),
		.pkt_tdata   (pkt_tdata),
		.pkt_tkeep   (pkt_tkeep),
		.pkt_tlast   (pkt_tlast),
		.pkt_empty   (pkt_empty),
		.pkt_rd_en   (pkt_rd_en),
		.phv_empty   (phv_empty),
		.phv_discard (phv_discard),
		.phv_rd_en   (phv_rd_en),
		.out_tdata   (out_tdata),
		.out_tkeep   (out_tkeep),
		.out_tlast   (out_tlast),
		.out_tvalid  (out_tvalid),
		.out_tready  (out_tready),
		.store       (u_hdr_if.fsm)
	);

endmodule

`default_nettype wire

//--- logic/hdr_store.sv
`timescale 1ns/1ns
`default_nettype none

module hdr_store import depar_pkg::*, cfg_pkg::*; (
	input  wire logic                       clk,
	input  wire logic                       aresetn,
	hdr_store_if.store                      store,
	input  wire act_entry_t                 entry,
	input  wire logic [NUM_CONT*CONT_W-1:0] phv_cont
);

	// slot j holds header bytes 8j..8j+7, byte k at bit 8*(k mod 8)
	logic [HDR_BEATS-1:0][DATA_W-1:0] data_q;
	logic [HDR_BEATS-1:0][KEEP_W-1:0] keep_q;
	logic [HDR_BEATS-1:0]             last_q;
	logic [HDR_BYTES*8-1:0]           patched;

	// later actions overwrite earlier ones
	always_comb begin : apply_actions
		logic [5:0]        byte_idx;
		logic [CONT_W-1:0] val;

		patched = data_q;
		byte_idx = '0;
		val = '0;
		for (int a = 0; a < NUM_ACT; a++) begin
			if (entry[a].valid) begin
				val = phv_cont[CONT_W*entry[a].cont +: CONT_W];
				for (int b = 0; b < CONT_W / 8; b++) begin
					byte_idx = {1'b0, entry[a].offset} + 6'(b);
					// msb of the container goes to the lowest offset
					if (byte_idx < 6'(HDR_BYTES)) begin
						patched[8*byte_idx +: 8] = val[8*(CONT_W/8-1-b) +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (store.cap_en) begin
			data_q[store.cap_idx] <= store.cap_data;
		end else if (store.patch_en) begin
			data_q <= patched;
		end
	end

	always_ff @(posedge clk) begin
		if (store.cap_en) begin
			keep_q[store.cap_idx] <= store.cap_keep;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			last_q <= '0;
		end else if (store.cap_en) begin
			last_q[store.cap_idx] <= store.cap_last;
		end
	end

	// beat read-out
	assign store.rd_data = data_q[store.rd_idx];
	assign store.rd_keep = keep_q[store.rd_idx];
	assign store.rd_last = last_q[store.rd_idx];

endmodule

`default_nettype wire

//--- logic/hdr_store_if.sv
`timescale 1ns/1ns
`default_nettype none

interface hdr_store_if import depar_pkg::*; ();

	// capture port
	logic                 cap_en;
	logic [HDR_IDX_W-1:0] cap_idx;
	logic [DATA_W-1:0]    cap_data;
	logic [KEEP_W-1:0]    cap_keep;
	logic                 cap_last;

	logic                 patch_en;

	// read-out, combinational on rd_idx
	logic [HDR_IDX_W-1:0] rd_idx;
	logic [DATA_W-1:0]    rd_data;
	logic [KEEP_W-1:0]    rd_keep;
	logic                 rd_last;

	modport fsm (
		output cap_en, cap_idx, cap_data, cap_keep, cap_last, patch_en, rd_idx,
		input  rd_data, rd_keep, rd_last
	);

	modport store (
		input  cap_en, cap_idx, cap_data, cap_keep, cap_last, patch_en, rd_idx,
		output rd_data, rd_keep, rd_last
	);

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the deparser testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module depar_tb \
	-f flist.f -Mdir obj_dir > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vdepar_tb > sim.log 2>&1
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "PASS: all tests" sim.log && echo "simulation passed" || { echo "no result in sim.log"; exit 1; }

//--- testbench/depar_assert.sv
`timescale 1ns/1ns
`default_nettype none

module depar_assert (
	input wire logic clk,
	input wire logic aresetn,
	input wire logic pkt_rd_en,
	input wire logic pkt_empty,
	input wire logic phv_rd_en,
	input wire logic phv_empty,
	input wire logic out_tvalid,
	input wire logic out_tready
);

	// set by a phv pop, cleared by the next packet fifo read
	logic phv_popped;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			phv_popped <= 1'b0;
		end else if (pkt_rd_en) begin
			phv_popped <= 1'b0;
		end else if (phv_rd_en) begin
			phv_popped <= 1'b1;
		end
	end

	a_pkt_pop: assert property (@(posedge clk) disable iff (!aresetn) pkt_rd_en |-> !pkt_empty)
		else $error("pkt_rd_en high while the packet FIFO is empty");

	a_phv_pop: assert property (@(posedge clk) disable iff (!aresetn) phv_rd_en |-> !phv_empty)
		else $error("phv_rd_en high while the PHV FIFO is empty");

	a_phv_once: assert property (@(posedge clk) disable iff (!aresetn) phv_rd_en |-> !phv_popped)
		else $error("second PHV pop without a packet read in between");

	a_ready: assert property (@(posedge clk) disable iff (!aresetn) !out_tready |=> !out_tvalid)
		else $error("out_tvalid issued after a cycle with out_tready low");

endmodule

bind depar_top depar_assert u_depar_assert (
	.clk        (clk),
	.aresetn    (aresetn),
	.pkt_rd_en  (pkt_rd_en),
	.pkt_empty  (pkt_empty),
	.phv_rd_en  (phv_rd_en),
	.phv_empty  (phv_empty),
	.out_tvalid (out_tvalid),
	.out_tready (out_tready)
);

`default_nettype wire

//--- testbench/depar_tb.sv
`timescale 1ns/1ns
`default_nettype none

module depar_tb import depar_pkg::*, cfg_pkg::*; ();

	localparam logic [2:0] MOD_ID = 3'd5;
	localparam int NUM_PKTS    = 50;
	localparam int MAX_LEN     = 8;
	localparam int TOTAL_BEATS = NUM_PKTS * MAX_LEN + 16;
	// last header flush once the input fifos are empty
	localparam int DRAIN_CYCLES = HDR_BEATS * 16;

	logic              clk, aresetn;
	logic [DATA_W-1:0] pkt_tdata;
	logic [KEEP_W-1:0] pkt_tkeep;
	logic              pkt_tlast, pkt_empty, pkt_rd_en;
	logic [PHV_W-1:0]  phv_data;
	logic              phv_empty, phv_rd_en;
	logic [DATA_W-1:0] out_tdata;
	logic [KEEP_W-1:0] out_tkeep;
	logic              out_tlast, out_tvalid, out_tready;
	logic              ctrl_tvalid, ctrl_tlast;
	logic [DATA_W-1:0] ctrl_tdata;

	// beats are {last, keep, data}
	logic [72:0]       pkt_q[$];
	logic [72:0]       pkt_beats[$];
	logic [72:0]       exp_q[$];
	logic [72:0]       exp_beat;
	logic [PHV_W-1:0]  phv_q[$];
	logic [63:0]       shadow [TBL_DEPTH];
	logic [31:0]       lfsr;
	logic              ready_pat [1024];
	logic              rand_ready, pkt_pop, phv_pop;
	int                cyc;

	tb_clk_gen u_clk_gen (.clk(clk), .aresetn(aresetn));

	depar_top #(.DEPARSER_MOD_ID(MOD_ID)) u_depar_top (
		.clk(clk), .aresetn(aresetn),
		.pkt_tdata(pkt_tdata), .pkt_tkeep(pkt_tkeep), .pkt_tlast(pkt_tlast),
		.pkt_empty(pkt_empty), .pkt_rd_en(pkt_rd_en),
		.phv_data(phv_data), .phv_empty(phv_empty), .phv_rd_en(phv_rd_en),
		.out_tdata(out_tdata), .out_tkeep(out_tkeep), .out_tlast(out_tlast),
		.out_tvalid(out_tvalid), .out_tready(out_tready),
		.ctrl_tvalid(ctrl_tvalid), .ctrl_tdata(ctrl_tdata), .ctrl_tlast(ctrl_tlast)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [15:0] rand_action();
		return {1'b1, 5'(rand_bits(8) % 29), 3'(rand_bits(3)), 7'(rand_bits(7))};
	endfunction

	function automatic logic [11:0] vlan_for(input logic [TBL_AW-1:0] idx);
		logic [11:0] v;
		v = 12'(rand_bits(12));
		v[TBL_IDX_LSB +: TBL_AW] = idx;
		return v;
	endfunction

	// expected beats of pkt_beats, from the shadow table
	function automatic void ref_deparse(input logic [PHV_W-1:0] phv);
		logic [63:0]            ent;
		logic [15:0]            act;
		logic [31:0]            val;
		logic [HDR_BYTES*8-1:0] hdr;
		int                     k;
		if (!phv[DISCARD_BIT]) begin
			ent = shadow[phv[VLAN_LSB + TBL_IDX_LSB +: TBL_AW]];
			hdr = '0;
			for (int j = 0; j < HDR_BEATS && j < pkt_beats.size(); j++) begin
				hdr[64*j +: 64] = pkt_beats[j][63:0];
			end
			for (int a = 0; a < NUM_ACT; a++) begin
				act = ent[63-16*a -: 16];
				if (act[15]) begin
					val = phv[32*act[9:7] +: 32];
					for (int b = 0; b < 4; b++) begin
						k = int'(act[14:10]) + b;
						if (k < HDR_BYTES) begin
							hdr[8*k +: 8] = val[31-8*b -: 8];
						end
					end
				end
			end
			for (int j = 0; j < pkt_beats.size(); j++) begin
				if (j < HDR_BEATS) begin
					exp_q.push_back({pkt_beats[j][72:64], hdr[64*j +: 64]});
				end else begin
					exp_q.push_back(pkt_beats[j]);
				end
			end
		end
	endfunction

	task automatic check_val(input string what, input logic [72:0] got, input logic [72:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic send_ctrl(input logic [2:0] mod_id, input logic [TBL_AW-1:0] addr,
			input logic [63:0] ent, input int nbeats);
		logic [63:0] word;
		for (int j = 0; j < nbeats; j++) begin
			word = '0;
			if (j == 0) begin
				word[CTRL_ADDR_LSB +: TBL_AW] = addr;
				word[MOD_ID_LSB +: 3] = mod_id;
			end else if (j == 1) begin
				for (int i = 0; i < 8; i++) begin
					word[8*i +: 8] = ent[63-8*i -: 8];
				end
			end else begin
				word = rand_bits(64);
			end
			@(negedge clk);
			ctrl_tvalid = 1'b1;
			ctrl_tdata = word;
			ctrl_tlast = (j == nbeats - 1);
		end
		@(negedge clk);
		ctrl_tvalid = 1'b0;
		ctrl_tlast = 1'b0;
		// only a matching two-beat packet writes
		if (nbeats == 2 && mod_id == MOD_ID) begin
			shadow[addr] = ent;
		end
	endtask

	task automatic send_pkt(input int len, input logic [11:0] vlan, input logic discard);
		logic [72:0]      beat;
		logic [PHV_W-1:0] phv;
		@(posedge clk);
		pkt_beats.delete();
		for (int j = 0; j < len; j++) begin
			beat[63:0] = rand_bits(64);
			beat[71:64] = (j == len - 1) ? (8'(rand_bits(8)) | 8'h01) : 8'hff;
			beat[72] = (j == len - 1);
			pkt_beats.push_back(beat);
			pkt_q.push_back(beat);
		end
		phv = '0;
		for (int c = 0; c < NUM_CONT; c++) begin
			phv[32*c +: 32] = 32'(rand_bits(32));
		end
		phv[VLAN_LSB +: 12] = vlan;
		phv[DISCARD_BIT] = discard;
		phv_q.push_back(phv);
		ref_deparse(phv);
	endtask

	// all input popped, then a bounded wait for the remaining output
	task automatic wait_drain();
		int waited;
		@(posedge clk);
		while (pkt_q.size() != 0 || phv_q.size() != 0) begin
			@(posedge clk);
		end
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		repeat (4) @(posedge clk);
	endtask

	// fifo models, pop on the edge where rd_en was high
	always @(posedge clk) begin
		pkt_pop <= pkt_rd_en;
		phv_pop <= phv_rd_en;
	end

	always @(negedge clk) begin
		if (pkt_pop) void'(pkt_q.pop_front());
		if (phv_pop) void'(phv_q.pop_front());
		pkt_empty = (pkt_q.size() == 0);
		if (pkt_q.size() != 0) begin
			{pkt_tlast, pkt_tkeep, pkt_tdata} = pkt_q[0];
		end
		phv_empty = (phv_q.size() == 0);
		if (phv_q.size() != 0) begin
			phv_data = phv_q[0];
		end
		out_tready = rand_ready ? ready_pat[cyc % 1024] : 1'b1;
		cyc++;
	end

	always @(negedge clk) begin
		if (aresetn && out_tvalid) begin
			if (exp_q.size() == 0) begin
				$display("output beat at %0t ns with no beat expected", $time);
				$display("FAIL: see errors above");
				$fatal(1, "unexpected output beat");
			end else begin
				exp_beat = exp_q.pop_front();
				check_val("output beat", {out_tlast, out_tkeep, out_tdata}, exp_beat);
			end
		end
	end

	initial begin : watchdog
		repeat (TOTAL_BEATS * 40) @(posedge clk);
		$display("timeout: run still going after %0d cycles", TOTAL_BEATS * 40);
		$display("FAIL: see errors above");
		$fatal(1, "timeout");
	end

	initial begin : stimulus
		logic [63:0] ent;
		int          len;
		pkt_tdata = '0;
		pkt_tkeep = '0;
		pkt_tlast = 1'b0;
		pkt_empty = 1'b1;
		phv_data = '0;
		phv_empty = 1'b1;
		out_tready = 1'b1;
		ctrl_tvalid = 1'b0;
		ctrl_tdata = '0;
		ctrl_tlast = 1'b0;
		rand_ready = 1'b0;
		pkt_pop = 1'b0;
		phv_pop = 1'b0;
		cyc = 0;
		lfsr = 32'd71000;
		for (int i = 0; i < TBL_DEPTH; i++) shadow[i] = '0;
		// tready high about three cycles in four
		for (int i = 0; i < 1024; i++) ready_pat[i] = (rand_bits(2) != 0);
		@(posedge aresetn);

		ent = {rand_action(), rand_action(), rand_action(), rand_action()};
		send_ctrl(MOD_ID, 5'd3, ent, 2);
		for (int n = 1; n <= HDR_BEATS; n++) send_pkt(n, vlan_for(5'd3), 1'b0);
		wait_drain();

		// longer packets, and an unwritten entry
		for (int n = 5; n <= MAX_LEN; n++) send_pkt(n, vlan_for(5'd3), 1'b0);
		send_pkt(6, vlan_for(5'd0), 1'b0);
		wait_drain();

		send_pkt(2, vlan_for(5'd3), 1'b0);
		send_pkt(1, vlan_for(5'd3), 1'b1);
		send_pkt(6, vlan_for(5'd3), 1'b1);
		send_pkt(3, vlan_for(5'd3), 1'b0);
		wait_drain();

		// bad control packets leave entry 3 alone
		ent = {rand_action(), rand_action(), rand_action(), rand_action()};
		send_ctrl(3'd2, 5'd3, ent, 2);
		send_ctrl(MOD_ID, 5'd3, ent, 3);
		send_ctrl(MOD_ID, 5'd3, ent, 1);
		for (int n = 2; n <= 6; n += 2) send_pkt(n, vlan_for(5'd3), 1'b0);
		wait_drain();

		ent = {rand_action(), rand_action(), rand_action(), rand_action()};
		send_ctrl(MOD_ID, 5'd7, ent, 2);
		rand_ready = 1'b1;
		for (int i = 0; i < 30; i++) begin
			len = 1 + int'(rand_bits(3));
			send_pkt(len, vlan_for(rand_bits(1) ? 5'd7 : 5'd3), rand_bits(3) == 0);
		end
		wait_drain();
		rand_ready = 1'b0;

		// overlapping writes on bytes 4..10
		ent = {1'b1, 5'd4, 3'd1, 7'd0, 1'b1, 5'd6, 3'd2, 7'd0,
			1'b1, 5'd5, 3'd3, 7'd0, 1'b1, 5'd7, 3'd4, 7'd0};
		send_ctrl(MOD_ID, 5'd9, ent, 2);
		for (int n = 0; n < 3; n++) send_pkt(4, vlan_for(5'd9), 1'b0);
		wait_drain();

		if (exp_q.size() != 0) begin
			$display("%0d expected beats never came out", exp_q.size());
			$display("FAIL: see errors above");
			$fatal(1, "missing beats");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD     = 8,
	parameter int RST_CYCLES = 5
) (
	output logic clk,
	output logic aresetn
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a falling edge
	initial begin
		aresetn = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;
	end

endmodule

`default_nettype wire
